/* l1_cache.sv */
`default_nettype none

`include "l1c_defs.svh"

module l1_cache (
	input wire clk,
	input wire reset,
	input wire access_i,
	input wire l1c_pkg::l1_req_t req_i,
	output logic hit_o,
	output l1c_pkg::line_t data_o,
	output logic collision_o,
	output l1c_pkg::strand_mask_t load_complete_o,
	output logic l2req_valid_o,
	output l1c_pkg::l2_req_t l2req_o,
	input wire l2req_ready_i,
	input wire l1c_pkg::l2_rsp_t l2rsp_i
);

	logic access_q;
	l1c_pkg::l1_req_t req_q;
	logic load_ack;
	logic inval;
	logic tag_hit;
	l1c_pkg::way_t hit_way;
	l1c_pkg::way_t victim_way;
	logic collision_early_q;
	logic collision_late;
	logic miss;
	l1c_pkg::line_t way_data [`L1C_NUM_WAYS];
	logic [`L1C_NUM_WAYS-1:0] data_wr;

	assign load_ack = l2rsp_i.valid && l2rsp_i.op == `L2RSP_LOAD_ACK;
	assign inval = l2rsp_i.valid && l2rsp_i.op == `L2RSP_INVALIDATE;

	l1c_tag tag_mem (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.addr_i(req_i.addr),
		.fill_i(load_ack),
		.fill_way_i(l2rsp_i.way),
		.fill_addr_i(l2rsp_i.addr),
		.inval_i(inval),
		.inval_addr_i(l2rsp_i.addr),
		.hit_o(tag_hit),
		.hit_way_o(hit_way)
	);

	// All four data ways are read with the tags and the hit way picks one
	for (genvar w = 0; w < `L1C_NUM_WAYS; w++)
	begin : g_data
		assign data_wr[w] = load_ack && l2rsp_i.way == l1c_pkg::way_t'(w);

		sram_1r1w #(.payload_t(l1c_pkg::line_t), .DEPTH(`L1C_NUM_SETS)) data_ram (
			.clk(clk),
			.rd_en_i(access_i),
			.rd_addr_i(req_i.addr.set),
			.rd_data_o(way_data[w]),
			.wr_en_i(data_wr[w]),
			.wr_addr_i(l2rsp_i.addr.set),
			.wr_data_i(l2rsp_i.data)
		);
	end

	assign data_o = way_data[hit_way];

	// The missed way is marked as used too so nothing evicts it before the fill
	l1c_lru lru (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.set_i(req_i.addr.set),
		.use_i(access_q),
		.use_way_i(tag_hit ? hit_way : victim_way),
		.victim_way_o(victim_way)
	);

	// A line returning while it is being looked up is in neither the tags nor the queue
	// Requesting it again would leave it in two ways
	assign collision_late = load_ack && access_q && l2rsp_i.addr == req_q.addr;
	assign collision_o = collision_early_q || collision_late;
	assign hit_o = tag_hit && !collision_o;
	assign miss = access_q && !tag_hit && !collision_o;

	l1c_miss_queue miss_queue (
		.clk(clk),
		.reset(reset),
		.miss_i(miss),
		.miss_req_i(req_q),
		.victim_way_i(victim_way),
		.l2req_valid_o(l2req_valid_o),
		.l2req_o(l2req_o),
		.l2req_ready_i(l2req_ready_i),
		.l2rsp_i(l2rsp_i),
		.load_complete_o(load_complete_o)
	);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			access_q <= 1'b0;
			collision_early_q <= 1'b0;
		end
		else
		begin
			access_q <= access_i;
			// Fill landing on the access edge goes unseen by the tag read
			collision_early_q <= access_i && load_ack && l2rsp_i.addr == req_i.addr;
		end
	end

	always_ff @(posedge clk)
	begin
		if (access_i)
			req_q <= req_i;
	end

endmodule

`default_nettype wire

/* l1c_defs.svh */
`ifndef L1C_DEFS_SVH
`define L1C_DEFS_SVH

// Four ways of 32 sets each
`define L1C_NUM_WAYS 4
`define L1C_NUM_SETS 32
`define L1C_SET_BITS 5

// A request names a whole line, so there are no offset bits
`define L1C_ADDR_BITS 26
`define L1C_TAG_BITS (`L1C_ADDR_BITS - `L1C_SET_BITS)
`define L1C_LINE_BITS 128

// Strands of the core that can each have one miss outstanding
`define L1C_NUM_STRANDS 4

// Opcodes carried on the L2 response channel
`define L2RSP_OP_BITS 2
`define L2RSP_LOAD_ACK 2'd0
`define L2RSP_INVALIDATE 2'd1

`endif

/* l1c_lru.sv */
`default_nettype none

`include "l1c_defs.svh"

module l1c_lru (
	input wire clk,
	input wire reset,
	input wire access_i,
	input wire [`L1C_SET_BITS-1:0] set_i,
	input wire use_i,
	input wire l1c_pkg::way_t use_way_i,
	output l1c_pkg::way_t victim_way_o
);

	// Age 0 is the most recent use and the highest age marks the victim
	l1c_pkg::way_t [`L1C_NUM_WAYS-1:0] age_q [`L1C_NUM_SETS];
	logic [`L1C_SET_BITS-1:0] set_q;
	l1c_pkg::way_t [`L1C_NUM_WAYS-1:0] set_age;
	l1c_pkg::way_t use_age;

	assign set_age = age_q[set_q];
	assign use_age = set_age[use_way_i];

	// The ages of a set are a permutation so exactly one way is the oldest
	always_comb
	begin
		victim_way_o = '0;
		for (int w = 0; w < `L1C_NUM_WAYS; w++)
			if (set_age[w] == l1c_pkg::way_t'(`L1C_NUM_WAYS - 1))
				victim_way_o = l1c_pkg::way_t'(w);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			set_q <= '0;
			// Way 0 starts as the youngest and way 3 as the oldest
			for (int s = 0; s < `L1C_NUM_SETS; s++)
				for (int w = 0; w < `L1C_NUM_WAYS; w++)
					age_q[s][w] <= l1c_pkg::way_t'(w);
		end
		else
		begin
			if (access_i)
				set_q <= set_i;
			// The used way becomes youngest and every way younger than it ages by one
			if (use_i)
			begin
				for (int w = 0; w < `L1C_NUM_WAYS; w++)
				begin
					if (l1c_pkg::way_t'(w) == use_way_i)
						age_q[set_q][w] <= '0;
					else if (set_age[w] < use_age)
						age_q[set_q][w] <= set_age[w] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* l1c_miss_queue.sv */
`default_nettype none

`include "l1c_defs.svh"

module l1c_miss_queue (
	input wire clk,
	input wire reset,
	input wire miss_i,
	input wire l1c_pkg::l1_req_t miss_req_i,
	input wire l1c_pkg::way_t victim_way_i,
	output logic l2req_valid_o,
	output l1c_pkg::l2_req_t l2req_o,
	input wire l2req_ready_i,
	input wire l1c_pkg::l2_rsp_t l2rsp_i,
	output l1c_pkg::strand_mask_t load_complete_o
);

	// One pending miss per strand since a strand waits on its load
	l1c_pkg::strand_mask_t valid_q;
	l1c_pkg::strand_mask_t issued_q;
	l1c_pkg::line_addr_t addr_q [`L1C_NUM_STRANDS];
	l1c_pkg::way_t way_q [`L1C_NUM_STRANDS];
	l1c_pkg::strand_t rr_q;
	l1c_pkg::strand_mask_t ack_mask;
	l1c_pkg::strand_mask_t merge_mask;
	l1c_pkg::strand_mask_t ready_mask;
	l1c_pkg::strand_t pick;
	logic pick_valid;
	logic load_ack;
	logic load_req;

	assign load_ack = l2rsp_i.valid && l2rsp_i.op == `L2RSP_LOAD_ACK;

	// Every strand waiting on the returned line finishes together
	always_comb
	begin
		for (int s = 0; s < `L1C_NUM_STRANDS; s++)
		begin
			ack_mask[s] = load_ack && valid_q[s] && addr_q[s] == l2rsp_i.addr;
			merge_mask[s] = valid_q[s] && !ack_mask[s] && addr_q[s] == miss_req_i.addr;
		end
	end

	assign ready_mask = valid_q & ~issued_q & ~ack_mask;

	// Round robin starting at the pointer so the closest strand after it wins
	always_comb
	begin
		l1c_pkg::strand_t idx;
		pick_valid = 1'b0;
		pick = rr_q;
		for (int i = `L1C_NUM_STRANDS - 1; i >= 0; i--)
		begin
			idx = rr_q + l1c_pkg::strand_t'(i);
			if (ready_mask[idx])
			begin
				pick_valid = 1'b1;
				pick = idx;
			end
		end
	end

	// The output register reloads when empty or when its request is taken
	assign load_req = pick_valid && (!l2req_valid_o || l2req_ready_i);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
			issued_q <= '0;
			rr_q <= '0;
			l2req_valid_o <= 1'b0;
			load_complete_o <= '0;
		end
		else
		begin
			load_complete_o <= ack_mask;
			if (load_req)
			begin
				l2req_valid_o <= 1'b1;
				rr_q <= pick + 1'b1;
			end
			else if (l2req_ready_i)
				l2req_valid_o <= 1'b0;
			valid_q <= valid_q & ~ack_mask;
			issued_q <= (issued_q & ~ack_mask)
				| (load_req ? l1c_pkg::strand_mask_t'(1) << pick : '0);
			// A miss to a line already pending rides on the earlier request
			if (miss_i)
			begin
				valid_q[miss_req_i.strand] <= 1'b1;
				issued_q[miss_req_i.strand] <= |merge_mask;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_i)
		begin
			addr_q[miss_req_i.strand] <= miss_req_i.addr;
			way_q[miss_req_i.strand] <= victim_way_i;
		end
		if (load_req)
			l2req_o <= '{strand: pick, way: way_q[pick], addr: addr_q[pick]};
	end

endmodule

`default_nettype wire

/* l1c_pkg.sv */
`default_nettype none

`include "l1c_defs.svh"

package l1c_pkg;

	typedef logic [`L1C_TAG_BITS-1:0] tag_t;
	typedef logic [`L1C_LINE_BITS-1:0] line_t;
	typedef logic [$clog2(`L1C_NUM_WAYS)-1:0] way_t;
	typedef logic [$clog2(`L1C_NUM_STRANDS)-1:0] strand_t;
	typedef logic [`L1C_NUM_STRANDS-1:0] strand_mask_t;

	// The set sits in the low bits and the tag above it
	typedef struct packed {
		tag_t tag;
		logic [`L1C_SET_BITS-1:0] set;
	} line_addr_t;

	// One access from the core
	typedef struct packed {
		strand_t strand;
		line_addr_t addr;
	} l1_req_t;

	// Line fetch sent to L2 with the way it should be filled into
	typedef struct packed {
		strand_t strand;
		way_t way;
		line_addr_t addr;
	} l2_req_t;

	// Response from L2, valid for a single cycle
	typedef struct packed {
		logic valid;
		logic [`L2RSP_OP_BITS-1:0] op;
		way_t way;
		line_addr_t addr;
		line_t data;
	} l2_rsp_t;

endpackage

`default_nettype wire

/* l1c_tag.sv */
`default_nettype none

`include "l1c_defs.svh"

module l1c_tag (
	input wire clk,
	input wire reset,
	input wire access_i,
	input wire l1c_pkg::line_addr_t addr_i,
	input wire fill_i,
	input wire l1c_pkg::way_t fill_way_i,
	input wire l1c_pkg::line_addr_t fill_addr_i,
	input wire inval_i,
	input wire l1c_pkg::line_addr_t inval_addr_i,
	output logic hit_o,
	output l1c_pkg::way_t hit_way_o
);

	// Each tag way is kept twice so that lookups and invalidates read in parallel
	l1c_pkg::tag_t lookup_tag [`L1C_NUM_WAYS];
	l1c_pkg::tag_t inval_tag [`L1C_NUM_WAYS];
	logic [`L1C_NUM_SETS-1:0][`L1C_NUM_WAYS-1:0] valid_q;
	logic [`L1C_NUM_WAYS-1:0] lookup_valid_q;
	logic access_q;
	l1c_pkg::tag_t req_tag_q;
	logic inval_q;
	l1c_pkg::line_addr_t inval_addr_q;
	logic [`L1C_NUM_WAYS-1:0] fill_mask;
	logic [`L1C_NUM_WAYS-1:0] clear_mask;
	logic [`L1C_NUM_WAYS-1:0] hit_mask;

	for (genvar w = 0; w < `L1C_NUM_WAYS; w++)
	begin : g_way
		assign fill_mask[w] = fill_i && fill_way_i == l1c_pkg::way_t'(w);

		sram_1r1w #(.payload_t(l1c_pkg::tag_t), .DEPTH(`L1C_NUM_SETS)) lookup_ram (
			.clk(clk),
			.rd_en_i(access_i),
			.rd_addr_i(addr_i.set),
			.rd_data_o(lookup_tag[w]),
			.wr_en_i(fill_mask[w]),
			.wr_addr_i(fill_addr_i.set),
			.wr_data_i(fill_addr_i.tag)
		);

		sram_1r1w #(.payload_t(l1c_pkg::tag_t), .DEPTH(`L1C_NUM_SETS)) inval_ram (
			.clk(clk),
			.rd_en_i(inval_i),
			.rd_addr_i(inval_addr_i.set),
			.rd_data_o(inval_tag[w]),
			.wr_en_i(fill_mask[w]),
			.wr_addr_i(fill_addr_i.set),
			.wr_data_i(fill_addr_i.tag)
		);

		// The invalidate tag read arrives a cycle later and is matched here
		assign clear_mask[w] = inval_q && valid_q[inval_addr_q.set][w]
			&& inval_tag[w] == inval_addr_q.tag;
		assign hit_mask[w] = lookup_valid_q[w] && lookup_tag[w] == req_tag_q;
	end

	// A line is only ever held in one way, so the mask has at most one bit set
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < `L1C_NUM_WAYS; w++)
			if (hit_mask[w])
				hit_way_o = l1c_pkg::way_t'(w);
	end

	assign hit_o = access_q && |hit_mask;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
			lookup_valid_q <= '0;
			access_q <= 1'b0;
			inval_q <= 1'b0;
		end
		else
		begin
			access_q <= access_i;
			inval_q <= inval_i;
			// Valid bits are sampled with the tag read so both show the same state
			// A clear landing on this edge is already folded in
			if (access_i)
			begin
				if (inval_q && inval_addr_q.set == addr_i.set)
					lookup_valid_q <= valid_q[addr_i.set] & ~clear_mask;
				else
					lookup_valid_q <= valid_q[addr_i.set];
			end
			if (inval_q)
				valid_q[inval_addr_q.set] <= valid_q[inval_addr_q.set] & ~clear_mask;
			// A fill to the same slot wins over the clear
			if (fill_i)
				valid_q[fill_addr_i.set][fill_way_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (access_i)
			req_tag_q <= addr_i.tag;
		if (inval_i)
			inval_addr_q <= inval_addr_i;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
l1c_pkg.sv
sram_1r1w.sv
l1c_tag.sv
l1c_lru.sv
l1c_miss_queue.sv
l1_cache.sv
tb_l2_model.sv
tb_l1_cache.sv

/* sram_1r1w.sv */
`default_nettype none

// Registered-read memory with one read and one write port
module sram_1r1w #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 32
) (
	input wire clk,
	input wire rd_en_i,
	input wire [$clog2(DEPTH)-1:0] rd_addr_i,
	output payload_t rd_data_o,
	input wire wr_en_i,
	input wire [$clog2(DEPTH)-1:0] wr_addr_i,
	input wire payload_t wr_data_i
);

	payload_t mem [DEPTH];

	// A read of the address being written gets the value from before the write
	always_ff @(posedge clk)
	begin
		if (rd_en_i)
			rd_data_o <= mem[rd_addr_i];
	end

	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

endmodule

`default_nettype wire

/* tb_l1_cache.sv */
`default_nettype none

`include "l1c_defs.svh"

module tb_l1_cache;

	// Each row of the stimulus table is one access, or an invalidate when inval is set
	typedef struct packed {
		logic [2:0] test;
		logic inval;
		l1c_pkg::strand_t strand;
		l1c_pkg::tag_t tag;
		logic [`L1C_SET_BITS-1:0] set;
		logic hit;
	} step_t;

	localparam int NUM_STEPS = 19;
	localparam int TIMEOUT = 200;

	// Expected hits in test 3 follow true LRU from the reset ages of set 12
	step_t steps [NUM_STEPS] = '{
		'{3'd1, 1'b0, 2'd0, 21'd1, 5'd3, 1'b0},
		'{3'd1, 1'b0, 2'd0, 21'd1, 5'd3, 1'b1},
		'{3'd3, 1'b0, 2'd1, 21'd10, 5'd12, 1'b0},
		'{3'd3, 1'b0, 2'd1, 21'd11, 5'd12, 1'b0},
		'{3'd3, 1'b0, 2'd1, 21'd12, 5'd12, 1'b0},
		'{3'd3, 1'b0, 2'd1, 21'd13, 5'd12, 1'b0},
		'{3'd3, 1'b0, 2'd1, 21'd10, 5'd12, 1'b1},
		'{3'd3, 1'b0, 2'd1, 21'd14, 5'd12, 1'b0},
		'{3'd3, 1'b0, 2'd1, 21'd10, 5'd12, 1'b1},
		'{3'd3, 1'b0, 2'd1, 21'd12, 5'd12, 1'b1},
		'{3'd3, 1'b0, 2'd1, 21'd13, 5'd12, 1'b1},
		'{3'd3, 1'b0, 2'd1, 21'd11, 5'd12, 1'b0},
		'{3'd4, 1'b0, 2'd3, 21'd21, 5'd20, 1'b0},
		'{3'd4, 1'b0, 2'd3, 21'd22, 5'd20, 1'b0},
		'{3'd4, 1'b0, 2'd3, 21'd21, 5'd20, 1'b1},
		'{3'd4, 1'b0, 2'd3, 21'd22, 5'd20, 1'b1},
		'{3'd4, 1'b1, 2'd3, 21'd21, 5'd20, 1'b0},
		'{3'd4, 1'b0, 2'd3, 21'd21, 5'd20, 1'b0},
		'{3'd4, 1'b0, 2'd3, 21'd22, 5'd20, 1'b1}
	};

	logic clk;
	logic reset;
	logic access;
	l1c_pkg::l1_req_t req;
	logic hit;
	l1c_pkg::line_t data;
	logic collision;
	l1c_pkg::strand_mask_t complete;
	logic l2req_valid;
	l1c_pkg::l2_req_t l2req;
	logic l2req_ready;
	l1c_pkg::l2_rsp_t l2rsp;
	logic stall;
	logic cmd_valid;
	logic [`L2RSP_OP_BITS-1:0] cmd_op;
	l1c_pkg::way_t cmd_way;
	l1c_pkg::line_addr_t cmd_addr;
	int accept_count;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_base = 0;
	logic prev_valid;
	logic prev_ready;
	l1c_pkg::l2_req_t prev_req;

	l1_cache UUT (
		.clk(clk),
		.reset(reset),
		.access_i(access),
		.req_i(req),
		.hit_o(hit),
		.data_o(data),
		.collision_o(collision),
		.load_complete_o(complete),
		.l2req_valid_o(l2req_valid),
		.l2req_o(l2req),
		.l2req_ready_i(l2req_ready),
		.l2rsp_i(l2rsp)
	);

	tb_l2_model l2 (
		.clk(clk),
		.reset(reset),
		.req_valid_i(l2req_valid),
		.req_i(l2req),
		.req_ready_o(l2req_ready),
		.rsp_o(l2rsp),
		.stall_i(stall),
		.cmd_valid_i(cmd_valid),
		.cmd_op_i(cmd_op),
		.cmd_way_i(cmd_way),
		.cmd_addr_i(cmd_addr),
		.accept_count_o(accept_count)
	);

	always #5 clk = ~clk;

	task automatic check_line(input string name, input l1c_pkg::line_t got,
		input l1c_pkg::line_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_mask(input string name, input l1c_pkg::strand_mask_t got,
		input l1c_pkg::strand_mask_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_req(input string name, input l1c_pkg::l2_req_t got,
		input l1c_pkg::l2_req_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	// The L2 returns four 32-bit copies of the address with copy i XORed with i
	function automatic l1c_pkg::line_t expected_line(input l1c_pkg::line_addr_t addr);
		l1c_pkg::line_t line;
		for (int i = 0; i < 4; i++)
			line[i*32 +: 32] = {6'd0, addr} ^ 32'(i);
		return line;
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "miss then hit";
			2: return "merging";
			3: return "replacement";
			4: return "invalidation";
			5: return "load collision";
			default: return "back-pressure";
		endcase
	endfunction

	task automatic end_test(input int n);
		tests_run++;
		if (errors > test_base)
		begin
			tests_failed++;
			$display("test %0d (%s): FAILED with %0d errors", n, test_name(n), errors - test_base);
		end
		else
			$display("test %0d (%s): ok", n, test_name(n));
		test_base = errors;
	endtask

	// One access whose results are sampled at the end of the cycle after it
	task automatic access_once(input l1c_pkg::strand_t sid, input l1c_pkg::line_addr_t a,
		output logic h, output l1c_pkg::line_t d, output logic c);
		@(negedge clk);
		access = 1'b1;
		req = '{strand: sid, addr: a};
		@(negedge clk);
		access = 1'b0;
		@(posedge clk);
		h = hit;
		d = data;
		c = collision;
	endtask

	// Four strands miss in consecutive cycles and each result is checked one cycle later
	task automatic miss_burst(input l1c_pkg::tag_t tag0, input logic [`L1C_SET_BITS-1:0] set,
		input bit same_line);
		l1c_pkg::line_addr_t a;
		for (int i = 0; i <= `L1C_NUM_STRANDS; i++)
		begin
			@(negedge clk);
			if (i < `L1C_NUM_STRANDS)
			begin
				a = '{tag: same_line ? tag0 : tag0 + l1c_pkg::tag_t'(i), set: set};
				access = 1'b1;
				req = '{strand: l1c_pkg::strand_t'(i), addr: a};
			end
			else
				access = 1'b0;
			@(posedge clk);
			if (i > 0)
				check_bit("hit_o", hit, 1'b0);
		end
	endtask

	task automatic wait_pulse(output l1c_pkg::strand_mask_t mask, output bit ok);
		int cycles;
		mask = '0;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
			if (complete != '0)
			begin
				mask = complete;
				ok = 1'b1;
			end
		end
		if (!ok)
			report_failure("no load completion arrived within the timeout");
	endtask

	task automatic l2_command(input logic [`L2RSP_OP_BITS-1:0] op, input l1c_pkg::way_t w,
		input l1c_pkg::line_addr_t a);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_way = w;
		cmd_addr = a;
	endtask

	task automatic run_step(input step_t s);
		l1c_pkg::line_addr_t a;
		logic h;
		l1c_pkg::line_t d;
		logic c;
		l1c_pkg::strand_mask_t mask;
		bit ok;
		a = '{tag: s.tag, set: s.set};
		if (s.inval)
		begin
			l2_command(`L2RSP_INVALIDATE, '0, a);
			@(negedge clk);
			cmd_valid = 1'b0;
			// The clear lands two edges after the response
			repeat (3) @(negedge clk);
		end
		else
		begin
			access_once(s.strand, a, h, d, c);
			check_bit("hit_o", h, s.hit);
			check_bit("collision_o", c, 1'b0);
			if (s.hit)
				check_line("data_o", d, expected_line(a));
			else
			begin
				wait_pulse(mask, ok);
				if (ok)
					check_mask("load_complete_o", mask, l1c_pkg::strand_mask_t'(1) << s.strand);
			end
		end
	endtask

	// A request that was not taken must be offered again unchanged
	always @(posedge clk)
	begin
		if (reset)
			prev_valid = 1'b0;
		else
		begin
			if (prev_valid && !prev_ready)
			begin
				check_bit("l2req_valid_o", l2req_valid, 1'b1);
				if (l2req_valid)
					check_req("l2req_o", l2req, prev_req);
			end
			prev_valid = l2req_valid;
			prev_ready = l2req_ready;
			prev_req = l2req;
		end
	end

	initial
	begin
		int cur;
		int base;
		l1c_pkg::line_addr_t a;
		logic h;
		l1c_pkg::line_t d;
		logic c;
		l1c_pkg::strand_mask_t mask;
		l1c_pkg::strand_mask_t seen;
		l1c_pkg::l2_req_t exp_req;
		bit ok;
		int cycles;
		void'($urandom(3946));
		clk = 1'b0;
		reset = 1'b1;
		access = 1'b0;
		req = '0;
		stall = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = '0;
		cmd_way = '0;
		cmd_addr = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		// Tests 1, 3 and 4 come from the table
		cur = steps[0].test;
		for (int i = 0; i < NUM_STEPS; i++)
		begin
			if (steps[i].test != cur)
			begin
				end_test(cur);
				cur = steps[i].test;
			end
			run_step(steps[i]);
		end
		end_test(cur);

		// All four strands miss one line and share a single L2 request
		@(negedge clk);
		base = accept_count;
		miss_burst(21'd2, 5'd7, 1'b1);
		wait_pulse(mask, ok);
		if (ok)
			check_mask("load_complete_o", mask, 4'b1111);
		repeat (12) @(negedge clk);
		check_count("accepted L2 requests", accept_count, base + 1);
		end_test(2);

		// The acknowledge for the line arrives in the cycle of its access
		a = '{tag: 21'd30, set: 5'd25};
		@(negedge clk);
		base = accept_count;
		l2_command(`L2RSP_LOAD_ACK, 2'd1, a);
		@(negedge clk);
		cmd_valid = 1'b0;
		access = 1'b1;
		req = '{strand: 2'd2, addr: a};
		@(negedge clk);
		access = 1'b0;
		@(posedge clk);
		check_bit("collision_o", collision, 1'b1);
		check_bit("hit_o", hit, 1'b0);
		repeat (12) @(negedge clk);
		check_count("accepted L2 requests", accept_count, base);
		// The acknowledge filled the line, so it hits now
		access_once(2'd2, a, h, d, c);
		check_bit("hit_o", h, 1'b1);
		check_bit("collision_o", c, 1'b0);
		check_line("data_o", d, expected_line(a));
		end_test(5);

		// Four different lines miss while L2 refuses every request
		@(negedge clk);
		base = accept_count;
		stall = 1'b1;
		repeat (2) @(negedge clk);
		miss_burst(21'd40, 5'd28, 1'b0);
		repeat (10) @(posedge clk);
		check_bit("l2req_valid_o", l2req_valid, 1'b1);
		// Strand 0 missed first and way 3 is the oldest in an untouched set
		exp_req = '{strand: 2'd0, way: 2'd3, addr: '{tag: 21'd40, set: 5'd28}};
		check_req("l2req_o", l2req, exp_req);
		@(negedge clk);
		stall = 1'b0;
		seen = '0;
		cycles = 0;
		while (seen != 4'b1111 && cycles < 4)
		begin
			wait_pulse(mask, ok);
			seen |= mask;
			cycles++;
		end
		check_mask("load_complete_o", seen, 4'b1111);
		@(negedge clk);
		check_count("accepted L2 requests", accept_count, base + 4);
		end_test(6);

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_l2_model.sv */
`default_nettype none

`include "l1c_defs.svh"

// Behavioral L2 that answers line requests after a random delay
module tb_l2_model (
	input wire clk,
	input wire reset,
	input wire req_valid_i,
	input wire l1c_pkg::l2_req_t req_i,
	output logic req_ready_o,
	output l1c_pkg::l2_rsp_t rsp_o,
	input wire stall_i,
	input wire cmd_valid_i,
	input wire [`L2RSP_OP_BITS-1:0] cmd_op_i,
	input wire l1c_pkg::way_t cmd_way_i,
	input wire l1c_pkg::line_addr_t cmd_addr_i,
	output int accept_count_o
);

	int unsigned cycle;
	int unsigned low_left;
	int unsigned due_q [$];
	l1c_pkg::l2_rsp_t rsp_q [$];
	logic stall_q;
	logic cmd_pending;
	l1c_pkg::l2_rsp_t cmd_rsp;

	// Four 32-bit copies of the address, copy i XORed with i
	function automatic l1c_pkg::line_t line_for(input l1c_pkg::line_addr_t addr);
		logic [31:0] word;
		word = {6'd0, addr};
		return {word ^ 32'd3, word ^ 32'd2, word ^ 32'd1, word};
	endfunction

	initial
	begin
		req_ready_o = 1'b0;
		rsp_o = '0;
	end

	// Transfers, stall requests and commands are all taken on the rising edge
	always @(posedge clk, posedge reset)
	begin
		l1c_pkg::l2_rsp_t rsp;
		if (reset)
		begin
			cycle = 0;
			accept_count_o = 0;
			stall_q = 1'b0;
			cmd_pending = 1'b0;
			due_q.delete();
			rsp_q.delete();
		end
		else
		begin
			cycle++;
			stall_q = stall_i;
			if (req_valid_i && req_ready_o)
			begin
				accept_count_o++;
				rsp = '{valid: 1'b1, op: `L2RSP_LOAD_ACK, way: req_i.way, addr: req_i.addr,
					data: line_for(req_i.addr)};
				rsp_q.push_back(rsp);
				due_q.push_back(cycle + $urandom_range(9, 2));
			end
			if (cmd_valid_i)
			begin
				cmd_pending = 1'b1;
				cmd_rsp = '{valid: 1'b1, op: cmd_op_i, way: cmd_way_i, addr: cmd_addr_i,
					data: line_for(cmd_addr_i)};
			end
		end
	end

	// Outputs change on the falling edge so the cache samples them cleanly
	always @(negedge clk)
	begin
		rsp_o = '0;
		if (reset)
		begin
			req_ready_o = 1'b0;
			low_left = 0;
		end
		else
		begin
			// A commanded response goes first and queued ones slip by a cycle
			if (cmd_pending)
			begin
				rsp_o = cmd_rsp;
				cmd_pending = 1'b0;
			end
			else if (due_q.size() > 0 && due_q[0] <= cycle)
			begin
				rsp_o = rsp_q.pop_front();
				void'(due_q.pop_front());
			end
			// Ready drops for random stretches unless the testbench holds it low
			if (stall_q)
				req_ready_o = 1'b0;
			else if (low_left > 0)
			begin
				low_left--;
				req_ready_o = 1'b0;
			end
			else if ($urandom_range(3, 0) == 0)
			begin
				low_left = $urandom_range(3, 0);
				req_ready_o = 1'b0;
			end
			else
				req_ready_o = 1'b1;
		end
	end

endmodule

`default_nettype wire
